/* core_pkg.sv */
`default_nettype none

package core_pkg;

    typedef logic [63:0] xlen_t;     // register value
    typedef logic [4:0]  reg_idx_t;  // register index
    typedef logic [31:0] instr_t;    // instruction word
    typedef logic [31:0] daddr_t;    // data address, low bits only

    typedef logic [2:0] alu_op_t;
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;

    typedef logic [1:0] fwd_sel_t;
    localparam fwd_sel_t FWD_REG = 2'd0;  // register file
    localparam fwd_sel_t FWD_EX  = 2'd1;  // alu output
    localparam fwd_sel_t FWD_MEM = 2'd2;  // memory stage result
    localparam fwd_sel_t FWD_WB  = 2'd3;  // writeback data

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    localparam logic [2:0] F3_ADD    = 3'b000;
    localparam logic [2:0] F3_XOR    = 3'b100;
    localparam logic [2:0] F3_OR     = 3'b110;
    localparam logic [2:0] F3_AND    = 3'b111;
    localparam logic [2:0] F3_DOUBLE = 3'b011;  // ld / sd width

    localparam int F7_SUB_BIT = 30;  // instruction bit, sub vs add

    typedef enum logic [0:0] {
        MEM_IDLE,
        MEM_WAIT
    } mem_state_e;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        alu_op_t  alu_op;
        xlen_t    op_a;
        xlen_t    op_b;
        xlen_t    store_data;
        logic     load;
        logic     store;
        logic     reg_we;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    result;      // alu value or data address
        xlen_t    store_data;
        logic     load;
        logic     store;
        logic     reg_we;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;       // set only for a write to rd != x0
        reg_idx_t rd;
        xlen_t    data;
    } mem_wb_t;

endpackage

`default_nettype wire

/* hazard_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl (
    input  wire core_pkg::reg_idx_t rs1_i,
    input  wire core_pkg::reg_idx_t rs2_i,
    input  wire                     use_rs1_i,
    input  wire                     use_rs2_i,
    input  wire core_pkg::id_ex_t   id_ex_i,
    input  wire core_pkg::ex_mem_t  ex_mem_i,
    input  wire core_pkg::mem_wb_t  mem_wb_i,
    input  wire                     mem_busy_i,
    output core_pkg::fwd_sel_t      fwd_a_sel_o,
    output core_pkg::fwd_sel_t      fwd_b_sel_o,
    output logic                    stall_id_o,
    output logic                    freeze_o
);

    // youngest writer wins
    function automatic core_pkg::fwd_sel_t pick_src(core_pkg::reg_idx_t rs);
        if (rs == '0) begin
            return core_pkg::FWD_REG;  // x0 never forwarded
        end
        if (id_ex_i.valid && id_ex_i.reg_we && id_ex_i.rd == rs) begin
            return core_pkg::FWD_EX;
        end
        if (ex_mem_i.valid && ex_mem_i.reg_we && ex_mem_i.rd == rs) begin
            return core_pkg::FWD_MEM;
        end
        if (mem_wb_i.valid && mem_wb_i.rd == rs) begin
            return core_pkg::FWD_WB;
        end
        return core_pkg::FWD_REG;
    endfunction

    // load data not available before writeback
    function automatic logic load_pending(core_pkg::reg_idx_t rs);
        logic in_ex;
        logic in_mem;
        in_ex  = id_ex_i.valid && id_ex_i.load && id_ex_i.rd == rs;
        in_mem = ex_mem_i.valid && ex_mem_i.load && ex_mem_i.rd == rs;
        return (rs != '0) && (in_ex || in_mem);
    endfunction

    always_comb begin
        fwd_a_sel_o = pick_src(rs1_i);
        fwd_b_sel_o = pick_src(rs2_i);  // also feeds store data
        stall_id_o  = (use_rs1_i && load_pending(rs1_i))
                   || (use_rs2_i && load_pending(rs2_i));
    end

    assign freeze_o = mem_busy_i;  // data access outstanding

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire core_pkg::reg_idx_t raddr_a_i,
    input  wire core_pkg::reg_idx_t raddr_b_i,
    output core_pkg::xlen_t         rdata_a_o,
    output core_pkg::xlen_t         rdata_b_o,
    input  wire core_pkg::mem_wb_t  wb_i
);

    core_pkg::xlen_t regs_q [1:31];  // x0 has no storage

    function automatic core_pkg::xlen_t read_port(core_pkg::reg_idx_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_i.valid && wb_i.rd == addr) begin
            return wb_i.data;  // same-cycle write shows through
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.rd != '0) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire core_pkg::instr_t   instr_i,
    input  wire                     instr_valid_i,
    input  wire                     stall_id_i,
    input  wire                     freeze_i,
    input  wire core_pkg::fwd_sel_t fwd_a_sel_i,
    input  wire core_pkg::fwd_sel_t fwd_b_sel_i,
    input  wire core_pkg::xlen_t    rdata_a_i,
    input  wire core_pkg::xlen_t    rdata_b_i,
    input  wire core_pkg::xlen_t    ex_result_i,
    input  wire core_pkg::xlen_t    mem_result_i,
    input  wire core_pkg::mem_wb_t  wb_i,
    output core_pkg::reg_idx_t      rs1_o,
    output core_pkg::reg_idx_t      rs2_o,
    output logic                    use_rs1_o,
    output logic                    use_rs2_o,
    output core_pkg::id_ex_t        id_ex_o
);

    core_pkg::instr_t   ir_q;
    logic               ir_valid_q;
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    core_pkg::reg_idx_t rd;
    core_pkg::xlen_t    imm_i;
    core_pkg::xlen_t    imm_s;
    core_pkg::xlen_t    rs1_val;
    core_pkg::xlen_t    rs2_val;
    logic               f7_ok;
    logic               is_op;
    logic               is_opimm;
    logic               is_load;
    logic               is_store;
    logic               legal;
    logic               issue;
    core_pkg::alu_op_t  alu_op;
    core_pkg::id_ex_t   id_ex_d;

    function automatic core_pkg::xlen_t fwd_mux(core_pkg::fwd_sel_t sel,
                                                core_pkg::xlen_t rf_val);
        case (sel)
            core_pkg::FWD_EX:  return ex_result_i;
            core_pkg::FWD_MEM: return mem_result_i;
            core_pkg::FWD_WB:  return wb_i.data;
            default:           return rf_val;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ir_valid_q <= 1'b0;
        end else if (!stall_id_i && !freeze_i) begin
            ir_valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_id_i && !freeze_i && instr_valid_i) begin
            ir_q <= instr_i;  // tb holds the word while stalled
        end
    end

    assign opcode = ir_q[6:0];
    assign rd     = ir_q[11:7];
    assign funct3 = ir_q[14:12];
    assign funct7 = ir_q[31:25];
    assign rs1_o  = ir_q[19:15];
    assign rs2_o  = ir_q[24:20];
    assign imm_i  = {{52{ir_q[31]}}, ir_q[31:20]};
    assign imm_s  = {{52{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};

    // only bit 30 may be set, and only for sub
    assign f7_ok    = ({funct7[6], funct7[4:0]} == '0)
                   && (!ir_q[core_pkg::F7_SUB_BIT] || funct3 == core_pkg::F3_ADD);
    assign is_op    = (opcode == core_pkg::OPC_OP) && f7_ok
                   && (funct3 inside {core_pkg::F3_ADD, core_pkg::F3_XOR,
                                      core_pkg::F3_OR, core_pkg::F3_AND});
    assign is_opimm = (opcode == core_pkg::OPC_OPIMM) && (funct3 == core_pkg::F3_ADD);
    assign is_load  = (opcode == core_pkg::OPC_LOAD) && (funct3 == core_pkg::F3_DOUBLE);
    assign is_store = (opcode == core_pkg::OPC_STORE) && (funct3 == core_pkg::F3_DOUBLE);
    assign legal    = ir_valid_q && (is_op || is_opimm || is_load || is_store);

    assign use_rs1_o = legal;
    assign use_rs2_o = ir_valid_q && (is_op || is_store);

    always_comb begin
        alu_op = core_pkg::ALU_ADD;  // addi, ld and sd add too
        if (is_op) begin
            case (funct3)
                core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
                core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
                core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
                default: alu_op = ir_q[core_pkg::F7_SUB_BIT] ? core_pkg::ALU_SUB
                                                             : core_pkg::ALU_ADD;
            endcase
        end
    end

    always_comb begin
        rs1_val = fwd_mux(fwd_a_sel_i, rdata_a_i);
        rs2_val = fwd_mux(fwd_b_sel_i, rdata_b_i);
    end

    assign issue   = ir_valid_q && !stall_id_i;  // low means bubble

    always_comb begin
        id_ex_d.valid      = issue;
        id_ex_d.rd         = rd;
        id_ex_d.alu_op     = alu_op;
        id_ex_d.op_a       = rs1_val;
        id_ex_d.op_b       = is_op ? rs2_val : (is_store ? imm_s : imm_i);
        id_ex_d.store_data = rs2_val;
        id_ex_d.load       = issue && is_load;
        id_ex_d.store      = issue && is_store;
        id_ex_d.reg_we     = issue && legal && !is_store && (rd != '0);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            id_ex_o.valid  <= 1'b0;
            id_ex_o.load   <= 1'b0;
            id_ex_o.store  <= 1'b0;
            id_ex_o.reg_we <= 1'b0;
        end else if (!freeze_i) begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

/* ex_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire core_pkg::id_ex_t id_ex_i,
    input  wire                   freeze_i,
    output core_pkg::xlen_t       ex_result_o,
    output core_pkg::ex_mem_t     ex_mem_o
);

    core_pkg::xlen_t alu_res;

    always_comb begin
        case (id_ex_i.alu_op)
            core_pkg::ALU_SUB: alu_res = id_ex_i.op_a - id_ex_i.op_b;
            core_pkg::ALU_AND: alu_res = id_ex_i.op_a & id_ex_i.op_b;
            core_pkg::ALU_OR:  alu_res = id_ex_i.op_a | id_ex_i.op_b;
            core_pkg::ALU_XOR: alu_res = id_ex_i.op_a ^ id_ex_i.op_b;
            default:           alu_res = id_ex_i.op_a + id_ex_i.op_b;  // add, address
        endcase
    end

    assign ex_result_o = alu_res;  // forward path into decode

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_mem_o.valid  <= 1'b0;
            ex_mem_o.load   <= 1'b0;
            ex_mem_o.store  <= 1'b0;
            ex_mem_o.reg_we <= 1'b0;
        end else if (!freeze_i) begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.result     <= alu_res;
            ex_mem_o.store_data <= id_ex_i.store_data;
            ex_mem_o.load       <= id_ex_i.load;
            ex_mem_o.store      <= id_ex_i.store;
            ex_mem_o.reg_we     <= id_ex_i.reg_we;
        end
    end

endmodule

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire core_pkg::ex_mem_t ex_mem_i,
    input  wire                    dmem_done_i,
    input  wire core_pkg::xlen_t   dmem_rdata_i,
    output logic                   dmem_req_o,
    output logic                   dmem_we_o,
    output core_pkg::daddr_t       dmem_addr_o,
    output core_pkg::xlen_t        dmem_wdata_o,
    output logic                   mem_busy_o,
    output core_pkg::xlen_t        mem_result_o,
    output core_pkg::mem_wb_t      mem_wb_o
);

    core_pkg::mem_state_e state_q;
    core_pkg::mem_state_e state_d;
    logic                 mem_op;
    logic                 done_now;

    assign mem_op   = ex_mem_i.valid && (ex_mem_i.load || ex_mem_i.store);
    assign done_now = (state_q == core_pkg::MEM_WAIT) && dmem_done_i;

    // idle cycle before every request keeps req low between accesses
    always_comb begin
        state_d = state_q;
        case (state_q)
            core_pkg::MEM_IDLE: begin
                if (mem_op) begin
                    state_d = core_pkg::MEM_WAIT;
                end
            end
            core_pkg::MEM_WAIT: begin
                if (dmem_done_i) begin
                    state_d = core_pkg::MEM_IDLE;
                end
            end
            default: state_d = core_pkg::MEM_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= core_pkg::MEM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign dmem_req_o   = (state_q == core_pkg::MEM_WAIT);
    assign dmem_we_o    = dmem_req_o && ex_mem_i.store;
    assign dmem_addr_o  = core_pkg::daddr_t'(ex_mem_i.result);  // low address bits
    assign dmem_wdata_o = ex_mem_i.store_data;

    assign mem_busy_o   = mem_op && !done_now;  // holds upstream stages
    assign mem_result_o = ex_mem_i.result;      // loads stall instead

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mem_wb_o.valid <= 1'b0;
        end else begin
            mem_wb_o.valid <= ex_mem_i.valid && ex_mem_i.reg_we && !mem_busy_o;  // bubble on wait
            mem_wb_o.rd    <= ex_mem_i.rd;
            mem_wb_o.data  <= ex_mem_i.load ? dmem_rdata_i : ex_mem_i.result;
        end
    end

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ns
`default_nettype none

module core_top (
    input  wire                   clk,
    input  wire                   rst_i,
    input  wire core_pkg::instr_t instr_i,
    input  wire                   instr_valid_i,
    output logic                  stall_o,
    output logic                  dmem_req_o,
    output logic                  dmem_we_o,
    output core_pkg::daddr_t      dmem_addr_o,
    output core_pkg::xlen_t       dmem_wdata_o,
    input  wire core_pkg::xlen_t  dmem_rdata_i,
    input  wire                   dmem_done_i,
    output logic                  wb_valid_o,
    output core_pkg::reg_idx_t    wb_rd_o,
    output core_pkg::xlen_t       wb_data_o
);

    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    logic               use_rs1;
    logic               use_rs2;
    core_pkg::fwd_sel_t fwd_a_sel;
    core_pkg::fwd_sel_t fwd_b_sel;
    logic               stall_id;
    logic               freeze;
    logic               mem_busy;
    core_pkg::xlen_t    rdata_a;
    core_pkg::xlen_t    rdata_b;
    core_pkg::xlen_t    ex_result;
    core_pkg::xlen_t    mem_result;
    core_pkg::id_ex_t   id_ex;
    core_pkg::ex_mem_t  ex_mem;
    core_pkg::mem_wb_t  mem_wb;

    assign stall_o    = stall_id || freeze;  // instruction not taken
    assign wb_valid_o = mem_wb.valid;
    assign wb_rd_o    = mem_wb.rd;
    assign wb_data_o  = mem_wb.data;

    hazard_ctrl hazard_ctrl_inst (
        .rs1_i(rs1), .rs2_i(rs2), .use_rs1_i(use_rs1), .use_rs2_i(use_rs2),
        .id_ex_i(id_ex), .ex_mem_i(ex_mem), .mem_wb_i(mem_wb), .mem_busy_i(mem_busy),
        .fwd_a_sel_o(fwd_a_sel), .fwd_b_sel_o(fwd_b_sel),
        .stall_id_o(stall_id), .freeze_o(freeze)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst_i(rst_i), .raddr_a_i(rs1), .raddr_b_i(rs2),
        .rdata_a_o(rdata_a), .rdata_b_o(rdata_b), .wb_i(mem_wb)
    );

    id_stage id_stage_inst (
        .clk(clk), .rst_i(rst_i), .instr_i(instr_i), .instr_valid_i(instr_valid_i),
        .stall_id_i(stall_id), .freeze_i(freeze),
        .fwd_a_sel_i(fwd_a_sel), .fwd_b_sel_i(fwd_b_sel),
        .rdata_a_i(rdata_a), .rdata_b_i(rdata_b),
        .ex_result_i(ex_result), .mem_result_i(mem_result), .wb_i(mem_wb),
        .rs1_o(rs1), .rs2_o(rs2), .use_rs1_o(use_rs1), .use_rs2_o(use_rs2),
        .id_ex_o(id_ex)
    );

    ex_stage ex_stage_inst (
        .clk(clk), .rst_i(rst_i), .id_ex_i(id_ex), .freeze_i(freeze),
        .ex_result_o(ex_result), .ex_mem_o(ex_mem)
    );

    mem_stage mem_stage_inst (
        .clk(clk), .rst_i(rst_i), .ex_mem_i(ex_mem),
        .dmem_done_i(dmem_done_i), .dmem_rdata_i(dmem_rdata_i),
        .dmem_req_o(dmem_req_o), .dmem_we_o(dmem_we_o),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
        .mem_busy_o(mem_busy), .mem_result_o(mem_result), .mem_wb_o(mem_wb)
    );

endmodule

`default_nettype wire

/* core_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module core_properties (
    input wire                     clk,
    input wire                     rst_i,
    input wire                     stall_i,
    input wire                     dmem_req_i,
    input wire                     dmem_we_i,
    input wire                     dmem_done_i,
    input wire                     wb_valid_i,
    input wire core_pkg::reg_idx_t wb_rd_i
);

    req_held: assert property (@(posedge clk) disable iff (rst_i)
        dmem_req_i && !dmem_done_i |=> dmem_req_i)  // level until done
        else $error("dmem_req_o fell before dmem_done_i");

    we_needs_req: assert property (@(posedge clk) disable iff (rst_i)
        dmem_we_i |-> dmem_req_i)
        else $error("dmem_we_o high without dmem_req_o");

    no_x0_report: assert property (@(posedge clk) disable iff (rst_i)
        wb_valid_i |-> wb_rd_i != 5'd0)
        else $error("retirement reported for x0");

    // sync reset, so checked one edge later
    quiet_in_reset: assert property (@(posedge clk)
        rst_i |=> !stall_i && !wb_valid_i && !dmem_req_i && !dmem_we_i)
        else $error("outputs active during reset");

endmodule

bind core_top core_properties core_properties_inst (
    .clk(clk), .rst_i(rst_i), .stall_i(stall_o),
    .dmem_req_i(dmem_req_o), .dmem_we_i(dmem_we_o), .dmem_done_i(dmem_done_i),
    .wb_valid_i(wb_valid_o), .wb_rd_i(wb_rd_o)
);

`default_nettype wire

/* tb_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_core;

    localparam int wb_latency   = 3;    // decode, execute, memory, writeback registers
    localparam int instr_budget = 240;  // instructions issued over all tests, rounded up

    logic               clk;
    logic               rst;
    core_pkg::instr_t   instr;
    logic               instr_valid;
    logic               stall;
    logic               dmem_req;
    logic               dmem_we;
    core_pkg::daddr_t   dmem_addr;
    core_pkg::xlen_t    dmem_wdata;
    core_pkg::xlen_t    dmem_rdata;
    logic               dmem_done;
    logic               wb_valid;
    core_pkg::reg_idx_t wb_rd;
    core_pkg::xlen_t    wb_data;

    int cycle = 0;
    int accept_cycle = 0;
    int last_wb_cycle = 0;
    int mem_delay = 0;
    int err_count = 0;
    int tests_run = 0;
    int tests_failed = 0;

    core_pkg::xlen_t    ref_regs [32];
    core_pkg::xlen_t    ref_mem [logic [31:0]];
    core_pkg::xlen_t    dut_mem [logic [31:0]];
    core_pkg::reg_idx_t exp_rd_q [$];
    core_pkg::xlen_t    exp_data_q [$];
    core_pkg::daddr_t   exp_addr_q [$];
    core_pkg::xlen_t    exp_wdata_q [$];

    core_top core_top_inst (
        .clk(clk), .rst_i(rst), .instr_i(instr), .instr_valid_i(instr_valid),
        .stall_o(stall), .dmem_req_o(dmem_req), .dmem_we_o(dmem_we),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
        .dmem_rdata_i(dmem_rdata), .dmem_done_i(dmem_done),
        .wb_valid_o(wb_valid), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20;
            cycle = cycle + 1;  // counted ahead of the rising edge
            clk = 1'b1;
            #20;
            clk = 1'b0;
        end
    end

    initial begin
        #((instr_budget * 12 + 100) * 40);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    function automatic core_pkg::instr_t r_type(input logic [6:0] f7, input core_pkg::reg_idx_t rs2,
                                                input core_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                                input core_pkg::reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic core_pkg::instr_t i_type(input logic [11:0] imm, input core_pkg::reg_idx_t rs1,
                                                input logic [2:0] f3, input core_pkg::reg_idx_t rd,
                                                input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic core_pkg::instr_t s_type(input logic [11:0] imm, input core_pkg::reg_idx_t rs2,
                                                input core_pkg::reg_idx_t rs1, input logic [2:0] f3,
                                                input logic [6:0] opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    // unwritten memory reads back a word built from its address
    function automatic core_pkg::xlen_t fill_word(input logic [31:0] addr);
        return {addr ^ 32'hc3a5_0f96, ~addr};
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            err_count++;
        end
    endtask

    // sequential ISA model, one call per accepted instruction
    task automatic run_model(input core_pkg::instr_t ins);
        core_pkg::reg_idx_t rd;
        core_pkg::xlen_t    a;
        core_pkg::xlen_t    b;
        core_pkg::xlen_t    imm_i;
        core_pkg::xlen_t    imm_s;
        core_pkg::xlen_t    res;
        logic [31:0]        addr;
        logic               writes;
        rd     = ins[11:7];
        a      = ref_regs[ins[19:15]];
        b      = ref_regs[ins[24:20]];
        imm_i  = 64'($signed(ins[31:20]));
        imm_s  = 64'($signed({ins[31:25], ins[11:7]}));
        res    = '0;
        writes = 1'b1;
        case (ins[6:0])
            core_pkg::OPC_OP: begin
                case ({ins[31:25], ins[14:12]})
                    10'b0000000_000: res = a + b;
                    10'b0100000_000: res = a - b;
                    10'b0000000_111: res = a & b;
                    10'b0000000_110: res = a | b;
                    10'b0000000_100: res = a ^ b;
                    default:         writes = 1'b0;
                endcase
            end
            core_pkg::OPC_OPIMM: begin
                writes = (ins[14:12] == 3'b000);  // addi only
                res    = a + imm_i;
            end
            core_pkg::OPC_LOAD: begin
                writes = (ins[14:12] == 3'b011);
                addr   = 32'(a + imm_i);
                res    = ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
            end
            core_pkg::OPC_STORE: begin
                writes = 1'b0;
                if (ins[14:12] == 3'b011) begin
                    addr = 32'(a + imm_s);
                    ref_mem[addr] = b;
                    exp_addr_q.push_back(addr);
                    exp_wdata_q.push_back(b);
                end
            end
            default: writes = 1'b0;
        endcase
        if (writes && rd != 5'd0) begin
            ref_regs[rd] = res;
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
        end
    endtask

    task automatic answer_request();
        if (dmem_we) begin
            dut_mem[dmem_addr] = dmem_wdata;
            if (exp_addr_q.size() == 0) begin
                $display("store to address %h seen while no store was expected", dmem_addr);
                err_count++;
            end else begin
                compare("dmem_addr_o", 64'(dmem_addr), 64'(exp_addr_q.pop_front()));
                compare("dmem_wdata_o", dmem_wdata, exp_wdata_q.pop_front());
            end
        end else begin
            dmem_rdata = dut_mem.exists(dmem_addr) ? dut_mem[dmem_addr] : fill_word(dmem_addr);
        end
    endtask

    // data memory, done after 1 to 4 cycles
    initial begin
        dmem_done  = 1'b0;
        dmem_rdata = '0;
        forever begin
            @(negedge clk);
            if (dmem_done) begin
                dmem_done = 1'b0;
            end else if (dmem_req) begin
                if (mem_delay == 0) begin
                    mem_delay = 1 + int'($urandom % 4);  // new request
                end
                mem_delay = mem_delay - 1;
                if (mem_delay == 0) begin
                    answer_request();
                    dmem_done = 1'b1;
                end
            end
        end
    end

    // retirement reports against the model, in order
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && wb_valid) begin
                last_wb_cycle = cycle;
                if (exp_rd_q.size() == 0) begin
                    $display("retirement of x%0d reported while none was expected", wb_rd);
                    err_count++;
                end else begin
                    compare("wb_rd_o", 64'(wb_rd), 64'(exp_rd_q.pop_front()));
                    compare("wb_data_o", wb_data, exp_data_q.pop_front());
                end
            end
        end
    end

    task automatic issue(input core_pkg::instr_t ins);
        @(negedge clk);
        instr       = ins;
        instr_valid = 1'b1;
        @(posedge clk);
        while (stall) begin
            @(posedge clk);  // word held until taken
        end
        accept_cycle = cycle;
        run_model(ins);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            instr_valid = 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        while (exp_rd_q.size() != 0 || exp_addr_q.size() != 0) begin
            @(negedge clk);
        end
        idle(6);  // room for stray reports
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic reset_values();
        int errs;
        errs = err_count;
        @(negedge clk);
        compare("stall_o", 64'(stall), 64'd0);
        compare("wb_valid_o", 64'(wb_valid), 64'd0);
        compare("dmem_req_o", 64'(dmem_req), 64'd0);
        report_test("reset_values", errs);
    endtask

    task automatic isolated_addi();
        int errs;
        int start;
        errs = err_count;
        issue(i_type(12'hf9d, 5'd0, 3'b000, 5'd1, core_pkg::OPC_OPIMM));  // x1 = -99
        start = accept_cycle;
        drain();
        compare("wb latency", 64'(last_wb_cycle - start), 64'(wb_latency));
        report_test("isolated_addi", errs);
    endtask

    task automatic forwarding_chain();
        int errs;
        errs = err_count;
        issue(i_type(12'h123, 5'd0, 3'b000, 5'd1, core_pkg::OPC_OPIMM));
        issue(i_type(12'hffb, 5'd0, 3'b000, 5'd2, core_pkg::OPC_OPIMM));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, core_pkg::OPC_OP));  // distances 1 and 2
        issue(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4, core_pkg::OPC_OP));  // distances 1 and 3
        issue(r_type(7'h00, 5'd3, 5'd4, 3'b100, 5'd5, core_pkg::OPC_OP));
        issue(r_type(7'h00, 5'd2, 5'd5, 3'b110, 5'd6, core_pkg::OPC_OP));
        issue(r_type(7'h00, 5'd4, 5'd6, 3'b111, 5'd7, core_pkg::OPC_OP));
        issue(i_type(12'h7ff, 5'd7, 3'b000, 5'd8, core_pkg::OPC_OPIMM));
        issue(r_type(7'h00, 5'd6, 5'd8, 3'b000, 5'd9, core_pkg::OPC_OP));
        drain();
        report_test("forwarding_chain", errs);
    endtask

    task automatic store_load_use();
        int errs;
        errs = err_count;
        issue(i_type(12'h100, 5'd0, 3'b000, 5'd10, core_pkg::OPC_OPIMM));  // base address
        issue(i_type(12'hc5b, 5'd0, 3'b000, 5'd11, core_pkg::OPC_OPIMM));
        issue(s_type(12'h008, 5'd11, 5'd10, 3'b011, core_pkg::OPC_STORE));
        issue(i_type(12'h008, 5'd10, 3'b011, 5'd12, core_pkg::OPC_LOAD));
        issue(r_type(7'h00, 5'd11, 5'd12, 3'b000, 5'd13, core_pkg::OPC_OP));  // load-use
        issue(i_type(12'h010, 5'd10, 3'b011, 5'd14, core_pkg::OPC_LOAD));    // never written
        issue(r_type(7'h20, 5'd12, 5'd14, 3'b000, 5'd15, core_pkg::OPC_OP));
        issue(s_type(12'h018, 5'd15, 5'd10, 3'b011, core_pkg::OPC_STORE));
        drain();
        report_test("store_load_use", errs);
    endtask

    task automatic x0_and_illegal();
        int errs;
        errs = err_count;
        issue(i_type(12'h055, 5'd0, 3'b000, 5'd0, core_pkg::OPC_OPIMM));   // addi x0
        issue(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd0, core_pkg::OPC_OP));   // add x0
        issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd5, core_pkg::OPC_OP));   // reads x0
        issue(32'h0000_0000);
        issue(r_type(7'h01, 5'd1, 5'd1, 3'b000, 5'd7, core_pkg::OPC_OP));   // mul
        issue(i_type(12'h003, 5'd1, 3'b001, 5'd7, core_pkg::OPC_OPIMM));    // slli
        issue(i_type(12'h000, 5'd0, 3'b010, 5'd7, core_pkg::OPC_LOAD));     // lw
        issue(s_type(12'h000, 5'd1, 5'd0, 3'b010, core_pkg::OPC_STORE));    // sw
        issue(32'h0000_0063);                                                // beq
        issue(r_type(7'h00, 5'd0, 5'd7, 3'b000, 5'd8, core_pkg::OPC_OP));
        issue(i_type(12'h000, 5'd0, 3'b000, 5'd9, core_pkg::OPC_OPIMM));
        drain();
        report_test("x0_and_illegal", errs);
    endtask

    task automatic random_mix();
        int                 errs;
        int                 kind;
        core_pkg::reg_idx_t rd;
        core_pkg::reg_idx_t rs1;
        core_pkg::reg_idx_t rs2;
        logic [11:0]        imm;
        logic [11:0]        offs;
        errs = err_count;
        for (int n = 0; n < 200; n++) begin
            kind = int'($urandom % 8);
            rd   = 5'($urandom % 8);  // few registers, many dependencies
            rs1  = 5'($urandom % 8);
            rs2  = 5'($urandom % 8);
            imm  = 12'($urandom);
            offs = 12'(8 * ($urandom % 8));
            case (kind)
                0: issue(r_type(7'h00, rs2, rs1, 3'b000, rd, core_pkg::OPC_OP));
                1: issue(r_type(7'h20, rs2, rs1, 3'b000, rd, core_pkg::OPC_OP));
                2: issue(r_type(7'h00, rs2, rs1, 3'b111, rd, core_pkg::OPC_OP));
                3: issue(r_type(7'h00, rs2, rs1, 3'b110, rd, core_pkg::OPC_OP));
                4: issue(r_type(7'h00, rs2, rs1, 3'b100, rd, core_pkg::OPC_OP));
                5: issue(i_type(imm, rs1, 3'b000, rd, core_pkg::OPC_OPIMM));
                6: issue(i_type(offs, 5'd0, 3'b011, rd, core_pkg::OPC_LOAD));
                default: issue(s_type(offs, rs2, 5'd0, 3'b011, core_pkg::OPC_STORE));
            endcase
        end
        drain();
        report_test("random_mix", errs);
    endtask

    initial begin
        void'($urandom(32'h841a));
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_values();
        isolated_addi();
        forwarding_chain();
        store_load_use();
        x0_and_illegal();
        random_mix();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
core_pkg.sv
hazard_ctrl.sv
reg_file.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
core_top.sv
core_properties.sv
tb_core.sv

/* run.sh */
#!/bin/sh
# compile and run tb_core with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f vlog.f \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_core > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1
